// File: board_top.f
+incdir+src
src/board_pkg.sv
src/inmp441_mic_receiver.sv
src/level_meter.sv
src/seven_seg_scanner.sv
src/static_seg_latch.sv
src/board_top.sv
verification/board_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the board_top testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing -Wno-fatal --top-module board_top_tb \
    -f board_top.f -Mdir "$obj_dir" -o board_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$obj_dir/board_top_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$log"; then
    exit 1
fi

exit 0

// File: verification/board_top_testdata.txt
// Each line holds sw[1] sw[0] and a 24-bit sample in hex
// sw[1] selects the peak display and sw[0] clears the peak
0 0 012345
0 0 6789ab
0 0 cdef01
0 0 fedcba
0 0 800000   // Most negative sample saturates
0 0 7fffff
0 1 000123
1 0 0a0000
1 0 040000
1 0 f00000
1 0 fff000
1 1 2a0000
1 0 050505
1 0 030000
0 0 123456
0 0 abcdef

// File: verification/board_top_tb.sv
`timescale 1ns/1ps

`include "board_params.svh"

module board_top_tb
    import board_pkg::*;
();

    localparam int clk_period    = 100;
    localparam int drive_dly     = 5;       // ns after the rising clock edge
    localparam int settle_clks   = 40;      // After the last data bit of a frame
    localparam int clks_per_test = 400;
    localparam int reset_clks    = 8;
    localparam int frame_clks    = 64 * 2 * `MIC_SCK_HALF;  // 64 serial clocks per frame

    logic                clk = 1'b0;
    logic                rst;
    logic [`W_SW-1:0]    sw;
    logic                mic_sd = 1'b0;
    logic                mic_sck;
    logic                mic_ws;
    logic                mic_lr;
    hex_seg_t            hex [`W_DIGIT];
    logic [`W_DIGIT-1:0] dp_led;
    logic [`W_LED-1:0]   level_led;

    logic [`W_SW-1:0]    t_sw [$];
    mic_sample_t         t_sample [$];
    bit                  tests_loaded = 1'b0;
    logic [23:0]         ref_peak;

    integer              seed = 31585;
    mic_sample_t         cur_sample = '0;   // Word for the next frame
    mic_sample_t         tx_word = '0;
    int                  slot = 0;
    logic                ws_seen = 1'b1;
    bit                  framing = 1'b0;    // Set once the first frame has opened
    time                 frame_start = 0;
    int                  words_sent = 0;
    logic [31:0]         rnd;

    board_top i_dut (.clk(clk), .rst(rst), .sw(sw), .mic_sd(mic_sd), .mic_sck(mic_sck),
        .mic_ws(mic_ws), .mic_lr(mic_lr), .hex0(hex[0]), .hex1(hex[1]), .hex2(hex[2]),
        .hex3(hex[3]), .hex4(hex[4]), .hex5(hex[5]), .dp_led(dp_led), .level_led(level_led));

    always #(clk_period / 2) clk = ~clk;

    // --------------------------------------------------
    // Microphone model

    always @(negedge mic_sck)
    begin
        #drive_dly;
        if (!mic_ws && ws_seen)
        begin
            if (framing)
                check_time("mic_ws frame period", frame_clks * clk_period,
                           $time - frame_start);
            framing     = 1'b1;
            frame_start = $time;
            slot        = 0;                // Frame opens on the ws fall
            tx_word     = cur_sample;
        end
        else
        begin
            slot = slot + 1;
            if (framing)
                check_bit("mic_ws", slot >= 32, mic_ws);   // Low for the left slot only
        end
        ws_seen = mic_ws;
        if (slot >= 1 && slot <= 24)
            mic_sd = tx_word[24 - slot];    // MSB one slot after ws
        else
        begin
            rnd    = $random(seed);
            mic_sd = rnd[0];                // Noise on unused slots
        end
        if (slot == 25)
            words_sent = words_sent + 1;    // Last data bit already sampled
    end

    // --------------------------------------------------
    // Reference rules

    function automatic logic [23:0] magnitude_of(input mic_sample_t s);
        if (!s[23])
            return s;
        if (s[22:0] == '0)
            return 24'h7f_ffff;             // No positive twin
        return ~s + 24'd1;
    endfunction

    // Standard hex glyphs, gfedcba, active low
    function automatic hex_seg_t glyph_of(input logic [3:0] v);
        case (v)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // --------------------------------------------------
    // Compare tasks

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_hex(input string name, input hex_seg_t expected,
                             input hex_seg_t actual);
        if (actual !== expected)
        begin
            $display("ERROR at time %0t: %s expected %07b, got %07b",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_dp(input string name, input logic [`W_DIGIT-1:0] expected,
                            input logic [`W_DIGIT-1:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR at time %0t: %s expected %06b, got %06b",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_level(input string name, input logic [`W_LED-1:0] expected,
                               input logic [`W_LED-1:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR at time %0t: %s expected %04b, got %04b",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERROR at time %0t: %s expected %b, got %b",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_time(input string name, input time expected, input time actual);
        if (actual !== expected)
        begin
            $display("ERROR at time %0t: %s expected %0t, got %0t",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_outputs(input logic [`W_SW-1:0] sw_now, input mic_sample_t smp);
        logic [23:0]         mag;
        logic [23:0]         show;
        logic [`W_DIGIT-1:0] dp_exp;
        mag    = magnitude_of(smp);
        show   = sw_now[1] ? ref_peak : smp;
        dp_exp = '0;
        dp_exp[`W_DIGIT-1] = sw_now[1];     // Peak marker on the top digit
        for (int n = 0; n < `W_DIGIT; n++)
            check_hex($sformatf("hex%0d", n), glyph_of(show[n*4 +: 4]), hex[n]);
        check_dp("dp_led", dp_exp, dp_led);
        check_level("level_led", mag[22:19], level_led);
        check_bit("mic_lr", 1'b0, mic_lr);
    endtask

    // --------------------------------------------------
    // Main sequence

    initial
    begin
        int          fd;
        string       line;
        logic [3:0]  f_sw1;
        logic [3:0]  f_sw0;
        logic [23:0] f_smp;
        int          sent_before;
        int          n_tested;
        rst      = 1'b1;
        sw       = '0;
        ref_peak = '0;
        n_tested = 0;
        fd = $fopen("verification/board_top_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open verification/board_top_testdata.txt for reading");
            stop_with_failure();
        end
        else
        begin
            while ($fgets(line, fd) != 0)
                if (line.len() > 4 && line.substr(0, 1) != "//"
                    && $sscanf(line, "%h %h %h", f_sw1, f_sw0, f_smp) == 3)
                begin
                    t_sw.push_back({f_sw1[0], f_sw0[0]});
                    t_sample.push_back(f_smp);
                end
            $fclose(fd);
            tests_loaded = 1'b1;

            repeat (reset_clks) @(posedge clk);
            #drive_dly;
            rst = 1'b0;
            #drive_dly;
            for (int n = 0; n < `W_DIGIT; n++)   // Blank until the first scan
                check_hex($sformatf("hex%0d", n), '1, hex[n]);
            check_dp("dp_led", '0, dp_led);
            check_level("level_led", '0, level_led);
            check_bit("mic_lr", 1'b0, mic_lr);

            for (int i = 0; i < t_sample.size(); i++)
            begin
                sw          = t_sw[i];
                cur_sample  = t_sample[i];  // Sent in the next frame
                sent_before = words_sent;
                if (t_sw[i][0])
                    ref_peak = '0;
                else if (magnitude_of(t_sample[i]) > ref_peak)
                    ref_peak = magnitude_of(t_sample[i]);
                wait (words_sent > sent_before);
                repeat (settle_clks) @(posedge clk);
                #drive_dly;
                check_outputs(t_sw[i], t_sample[i]);
                n_tested++;
            end

            if (n_tested == 0)
            begin
                $display("The test data file holds no test lines");
                stop_with_failure();
            end
            else
            begin
                $display("Testbench passed");
                $finish;
            end
        end
    end

    // --------------------------------------------------
    // Watchdog

    initial
    begin
        int limit;
        wait (tests_loaded);
        limit = t_sample.size() * clks_per_test + reset_clks + clks_per_test;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run hung and did not finish within %0d clock cycles", limit);
        stop_with_failure();
    end

endmodule

// File: src/board_top.sv
`timescale 1ns/1ps

`include "board_params.svh"

module board_top
    import board_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [`W_SW-1:0]    sw,
    input  logic                mic_sd,
    output logic                mic_sck,
    output logic                mic_ws,
    output logic                mic_lr,
    output hex_seg_t            hex0,
    output hex_seg_t            hex1,
    output hex_seg_t            hex2,
    output hex_seg_t            hex3,
    output hex_seg_t            hex4,
    output hex_seg_t            hex5,
    output logic [`W_DIGIT-1:0] dp_led,
    output logic [`W_LED-1:0]   level_led
);

    mic_sample_t sample;
    logic        sample_valid;
    logic [23:0] show_value;
    logic        peak_shown;
    seg_t        abcdefgh;
    digit_sel_t  digit;

    assign mic_lr = 1'b0;                   // Left channel slot

    // --------------------------------------------------

    inmp441_mic_receiver i_mic (.clk(clk), .rst(rst), .sd(mic_sd), .sck(mic_sck),
        .ws(mic_ws), .sample(sample), .sample_valid(sample_valid));

    level_meter i_meter (.clk(clk), .rst(rst), .sample(sample),
        .sample_valid(sample_valid), .clear_peak(sw[0]), .mode(display_mode_e'(sw[1])),
        .show_value(show_value), .peak_shown(peak_shown), .level_led(level_led));

    seven_seg_scanner i_scanner (.clk(clk), .rst(rst), .show_value(show_value),
        .peak_shown(peak_shown), .abcdefgh(abcdefgh), .digit(digit));

    static_seg_latch i_latch (.clk(clk), .rst(rst), .abcdefgh(abcdefgh), .digit(digit),
        .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5),
        .dp(dp_led));

endmodule

// File: src/static_seg_latch.sv
`timescale 1ns/1ps

`include "board_params.svh"

module static_seg_latch
    import board_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  seg_t                abcdefgh,
    input  digit_sel_t          digit,
    output hex_seg_t            hex0,
    output hex_seg_t            hex1,
    output hex_seg_t            hex2,
    output hex_seg_t            hex3,
    output hex_seg_t            hex4,
    output hex_seg_t            hex5,
    output logic [`W_DIGIT-1:0] dp
);

    seg_t     hgfedcba;                     // Bit 0 is segment a
    hex_seg_t hex_r [`W_DIGIT];

    always_comb
        for (int i = 0; i < $bits(seg_t); i++)
            hgfedcba[i] = abcdefgh[$bits(seg_t) - 1 - i];

    // --------------------------------------------------
    // Sticky per-digit registers

    for (genvar n = 0; n < `W_DIGIT; n++)
    begin : g_digit
        always_ff @(posedge clk or posedge rst)
            if (rst)
            begin
                hex_r[n] <= '1;             // Blank
                dp[n]    <= 1'b0;
            end
            else if (digit[n])
            begin
                hex_r[n] <= ~hgfedcba[6:0]; // Active-low segments
                dp[n]    <=  hgfedcba[7];
            end
    end

    assign {hex5, hex4, hex3, hex2, hex1, hex0} =
        {hex_r[5], hex_r[4], hex_r[3], hex_r[2], hex_r[1], hex_r[0]};

    a_digit_onehot0: assert property (@(posedge clk) disable iff (rst)
        $onehot0(digit));

endmodule

// File: src/seven_seg_scanner.sv
`timescale 1ns/1ps

`include "board_params.svh"

module seven_seg_scanner
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [23:0] show_value,
    input  logic        peak_shown,
    output seg_t        abcdefgh,
    output digit_sel_t  digit
);

    localparam int div_w = $clog2(`SCAN_DIV);

    logic [div_w-1:0] div_cnt;
    digit_sel_t       scan;
    logic [3:0]       nibble;
    seg_t             glyph;

    // --------------------------------------------------
    // Digit rotation

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            div_cnt <= '0;
            scan    <= digit_sel_t'(1);     // Start on digit 0
        end
        else if (div_cnt == div_w'(`SCAN_DIV - 1))
        begin
            div_cnt <= '0;
            scan    <= {scan[`W_DIGIT-2:0], scan[`W_DIGIT-1]};
        end
        else
            div_cnt <= div_cnt + 1'b1;

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < `W_DIGIT; i++)
            if (scan[i])
                nibble = show_value[i*4 +: 4];
    end

    // --------------------------------------------------
    // Hex glyphs, abcdefgh

    always_comb
        case (nibble)
            4'h0: glyph = 8'hfc;    4'h1: glyph = 8'h60;
            4'h2: glyph = 8'hda;    4'h3: glyph = 8'hf2;
            4'h4: glyph = 8'h66;    4'h5: glyph = 8'hb6;
            4'h6: glyph = 8'hbe;    4'h7: glyph = 8'he0;
            4'h8: glyph = 8'hfe;    4'h9: glyph = 8'hf6;
            4'ha: glyph = 8'hee;    4'hb: glyph = 8'h3e;
            4'hc: glyph = 8'h9c;    4'hd: glyph = 8'h7a;
            4'he: glyph = 8'h9e;    default: glyph = 8'h8e;
        endcase

    assign abcdefgh = glyph | seg_t'(scan[`W_DIGIT-1] & peak_shown);  // Peak marker on top digit
    assign digit    = scan;

    a_digit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(digit));

endmodule

// File: src/level_meter.sv
`timescale 1ns/1ps

`include "board_params.svh"

module level_meter
    import board_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  mic_sample_t         sample,
    input  logic                sample_valid,
    input  logic                clear_peak,
    input  display_mode_e       mode,
    output logic [23:0]         show_value,
    output logic                peak_shown,
    output logic [`W_LED-1:0]   level_led
);

    logic [23:0] magnitude;
    logic [23:0] peak;
    logic [23:0] peak_next;

    // --------------------------------------------------
    // Magnitude and peak

    always_comb
    begin
        if (!sample[23])
            magnitude = sample;
        else if (sample == {1'b1, 23'd0})
            magnitude = 24'h7f_ffff;        // Saturate most negative sample
        else
            magnitude = -sample;
    end

    always_comb
    begin
        peak_next = peak;
        if (clear_peak)
            peak_next = '0;
        else if (sample_valid && magnitude > peak)
            peak_next = magnitude;
    end

    always_ff @(posedge clk or posedge rst)
        if (rst)
            peak <= '0;
        else
            peak <= peak_next;

    // --------------------------------------------------
    // Display value and LEDs

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            show_value <= '0;
            peak_shown <= 1'b0;
            level_led  <= '0;
        end
        else
        begin
            show_value <= (mode == mode_peak) ? peak_next : sample;
            peak_shown <= (mode == mode_peak);
            if (sample_valid)
                level_led <= magnitude[22 -: `W_LED];   // Coarse level bar
        end

    a_peak_hold: assert property (@(posedge clk) disable iff (rst)
        !clear_peak |=> peak >= $past(peak));

endmodule

// File: src/inmp441_mic_receiver.sv
`timescale 1ns/1ps

`include "board_params.svh"

module inmp441_mic_receiver
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sd,
    output logic        sck,
    output logic        ws,
    output mic_sample_t sample,
    output logic        sample_valid
);

    localparam int div_w = $clog2(`MIC_SCK_HALF);

    logic [div_w-1:0] div_cnt;
    logic             sck_tick;
    logic             sck_rise;
    logic             sck_fall;
    logic [5:0]       slot_cnt;       // Serial clock slot within the frame
    logic [5:0]       slot_next;
    logic [4:0]       bit_cnt;        // Data bits captured so far
    logic [22:0]      shreg;          // Bits ahead of the LSB
    mic_state_e       state;

    // --------------------------------------------------
    // Serial clock and word select

    assign sck_tick  = (div_cnt == div_w'(`MIC_SCK_HALF - 1));
    assign sck_rise  = sck_tick & ~sck;
    assign sck_fall  = sck_tick &  sck;
    assign slot_next = slot_cnt + 6'd1;

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_tick)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            slot_cnt <= '1;                 // First fall opens a frame
            ws       <= 1'b1;
        end
        else if (sck_fall)
        begin
            slot_cnt <= slot_next;
            ws       <= slot_next[5];       // Low for slots 0 to 31
        end

    // --------------------------------------------------
    // Bit capture

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            state   <= rx_wait_ws;
            bit_cnt <= '0;
        end
        else
            case (state)
                rx_wait_ws: if (sck_fall && slot_next == 6'd0) state <= rx_skip;
                rx_skip:
                    if (sck_rise)
                    begin
                        state   <= rx_shift;
                        bit_cnt <= '0;
                    end
                rx_shift:
                    if (sck_rise)
                    begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'd23)
                            state <= rx_done;
                    end
                default:    state <= rx_wait_ws;
            endcase

    always_ff @(posedge clk)
        if (state == rx_shift && sck_rise)
            shreg <= {shreg[21:0], sd};

    always_ff @(posedge clk or posedge rst)
        if (rst)
            sample <= '0;
        else if (state == rx_shift && sck_rise && bit_cnt == 5'd23)
            sample <= {shreg, sd};          // Held until the next frame

    assign sample_valid = (state == rx_done);

    a_valid_single: assert property (@(posedge clk) disable iff (rst)
        sample_valid |=> !sample_valid);

endmodule

// File: src/board_pkg.sv
`include "board_params.svh"

package board_pkg;

    // --------------------------------------------------
    // Data paths

    typedef logic signed [23:0]       mic_sample_t;  // Two's complement mic word
    typedef logic        [7:0]        seg_t;         // abcdefgh, active high
    typedef logic        [`W_DIGIT-1:0] digit_sel_t; // One-hot digit select
    typedef logic        [6:0]        hex_seg_t;     // gfedcba, active low

    // --------------------------------------------------
    // Modes and states

    typedef enum logic
    {
        mode_sample = 1'b0,  // Raw sample bits
        mode_peak   = 1'b1   // Held peak magnitude
    } display_mode_e;

    typedef enum logic [1:0]
    {
        rx_wait_ws = 2'd0,  // Wait for start of left slot
        rx_skip    = 2'd1,  // One-bit I2S delay
        rx_shift   = 2'd2,  // 24 data bits, MSB first
        rx_done    = 2'd3   // Sample ready
    } mic_state_e;

endpackage

// File: src/board_params.svh
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// --------------------------------------------------
// Board constants

`define CLK_MHZ       50   // System clock rate
`define W_DIGIT       6    // Seven-segment displays on the board
`define W_SW          2    // User switches
`define W_LED         4    // Level bar LEDs

// --------------------------------------------------
// Microphone and display timing

// Serial clock period is twice this many clk cycles
`define MIC_SCK_HALF  2
`define SCAN_DIV      4    // clk cycles per selected digit

`endif
